/* design/memprobe_pkg.sv */
`default_nettype none

package memprobe_pkg;

  // Serial timing, fixed divider in place of a prescale port
  localparam int UART_BIT_CYCLES = 16;
  localparam int BIT_CNT_BITS = $clog2(UART_BIT_CYCLES);

  localparam int WORD_BITS = 32;
  localparam int ADDR_BITS = 8;     // 256 words
  localparam int COUNT_BITS = WORD_BITS / 2;  // Each half of the status word
  localparam int NIBBLES = WORD_BITS / 4;

  typedef logic [WORD_BITS-1:0] word_t;
  typedef logic [ADDR_BITS-1:0] addr_t;
  typedef logic [7:0] byte_t;
  typedef logic [BIT_CNT_BITS-1:0] bit_cnt_t;
  typedef logic [$clog2(NIBBLES)-1:0] nib_idx_t;

  // Reload values for the per-bit down counters
  localparam bit_cnt_t BIT_CNT_LAST = bit_cnt_t'(UART_BIT_CYCLES - 1);
  localparam bit_cnt_t BIT_CNT_HALF = bit_cnt_t'(UART_BIT_CYCLES / 2 - 1);

  localparam nib_idx_t NIB_FIRST = nib_idx_t'(NIBBLES - 1);  // Most significant nibble

  // Command opcodes, printable so a terminal can drive them
  localparam byte_t OP_WRITE = "w";
  localparam byte_t OP_READ = "r";
  localparam byte_t OP_STATUS = "s";

  localparam byte_t CHAR_NEWLINE = 8'h0a;

endpackage

`default_nettype wire

/* design/uart_rx.sv */
`default_nettype none

module uart_rx
  import memprobe_pkg::*;
(
  input  logic  clock,
  input  logic  reset_i,
  input  logic  rx_i,
  output byte_t byte_o,
  output logic  strobe_o
);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  rx_state_t  state_q;
  bit_cnt_t   cnt_q;
  logic [2:0] bit_idx_q;
  logic       rx_meta_q;
  logic       rx_sync_q;
  logic       rx_prev_q;
  logic       strobe_q;
  byte_t      shift_q;

  // Two-flop synchroniser plus one more stage for the edge
  always_ff @(posedge clock) begin
    if (reset_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
      rx_prev_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
      rx_prev_q <= rx_sync_q;
    end
  end

  always_ff @(posedge clock) begin
    if (reset_i) begin
      state_q   <= RX_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      strobe_q  <= 1'b0;
    end else begin
      strobe_q <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          if (rx_prev_q && !rx_sync_q) begin  // Falling edge of start bit
            state_q <= RX_START;
            cnt_q   <= BIT_CNT_HALF;
          end
        end
        RX_START: begin
          if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
          end else if (!rx_sync_q) begin
            state_q   <= RX_DATA;
            cnt_q     <= BIT_CNT_LAST;
            bit_idx_q <= '0;
          end else begin
            state_q <= RX_IDLE;  // Glitch, not a start bit
          end
        end
        RX_DATA: begin
          if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
          end else begin
            cnt_q     <= BIT_CNT_LAST;
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end
        end
        default: begin
          if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
          end else begin
            strobe_q <= rx_sync_q;  // Framing error gives no strobe
            state_q  <= RX_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state_q == RX_DATA && cnt_q == '0) begin
      shift_q <= {rx_sync_q, shift_q[7:1]};  // LSB arrives first
    end
  end

  assign byte_o   = shift_q;
  assign strobe_o = strobe_q;

endmodule

`default_nettype wire

/* design/uart_tx.sv */
`default_nettype none

module uart_tx
  import memprobe_pkg::*;
(
  input  logic  clock,
  input  logic  reset_i,
  input  logic  valid_i,
  input  byte_t data_i,
  output logic  ready_o,
  output logic  busy_o,
  output logic  tx_o
);

  logic       busy_q;
  logic       tx_q;
  bit_cnt_t   cnt_q;
  logic [3:0] bits_left_q;  // Data bits plus stop bit still to go
  logic [8:0] frame_q;

  always_ff @(posedge clock) begin
    if (reset_i) begin
      busy_q      <= 1'b0;
      tx_q        <= 1'b1;
      cnt_q       <= '0;
      bits_left_q <= '0;
    end else if (!busy_q) begin
      if (valid_i) begin
        busy_q      <= 1'b1;
        tx_q        <= 1'b0;  // Start bit
        cnt_q       <= BIT_CNT_LAST;
        bits_left_q <= 4'd9;
      end
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end else if (bits_left_q == '0) begin
      busy_q <= 1'b0;  // Stop bit finished, line already high
    end else begin
      tx_q        <= frame_q[0];
      cnt_q       <= BIT_CNT_LAST;
      bits_left_q <= bits_left_q - 1'b1;
    end
  end

  // Data then stop bit, shifted out LSB first
  always_ff @(posedge clock) begin
    if (!busy_q && valid_i) begin
      frame_q <= {1'b1, data_i};
    end else if (busy_q && cnt_q == '0) begin
      frame_q <= {1'b1, frame_q[8:1]};
    end
  end

  assign ready_o = !busy_q;
  assign busy_o  = busy_q;
  assign tx_o    = tx_q;

endmodule

`default_nettype wire

/* design/cmd_ctrl.sv */
`default_nettype none

module cmd_ctrl
  import memprobe_pkg::*;
(
  input  logic  clock,
  input  logic  reset_i,
  input  byte_t rx_byte_i,
  input  logic  rx_strobe_i,
  input  logic  dumping_i,
  input  word_t mem_rdata_i,
  output logic  mem_we_o,
  output logic  mem_re_o,
  output addr_t mem_addr_o,
  output word_t mem_wdata_o,
  output logic  dump_start_o,
  output word_t dump_word_o,
  output logic  configured_o
);

  typedef enum logic [2:0] {
    CMD_IDLE,
    CMD_WR_ADDR,
    CMD_WR_DATA,
    CMD_RD_ADDR,
    CMD_RD_WAIT,
    CMD_RD_LOAD
  } cmd_state_t;

  cmd_state_t            state_q;
  logic [1:0]            data_cnt_q;
  logic                  mem_we_q;
  logic                  mem_re_q;
  logic                  dump_start_q;
  logic                  configured_q;
  logic [COUNT_BITS-1:0] wr_cnt_q;
  logic [COUNT_BITS-1:0] rd_cnt_q;
  addr_t                 mem_addr_q;
  word_t                 wdata_q;
  word_t                 dump_word_q;
  logic                  rx_take;

  // Bytes arriving during a reply are thrown away
  assign rx_take = rx_strobe_i && !dumping_i;

  always_ff @(posedge clock) begin
    if (reset_i) begin
      state_q      <= CMD_IDLE;
      data_cnt_q   <= '0;
      mem_we_q     <= 1'b0;
      mem_re_q     <= 1'b0;
      dump_start_q <= 1'b0;
      configured_q <= 1'b0;
      wr_cnt_q     <= '0;
      rd_cnt_q     <= '0;
    end else begin
      configured_q <= 1'b1;
      mem_we_q     <= 1'b0;
      mem_re_q     <= 1'b0;
      dump_start_q <= 1'b0;
      case (state_q)
        CMD_IDLE: begin
          if (rx_take) begin
            case (rx_byte_i)
              OP_WRITE:  state_q <= CMD_WR_ADDR;
              OP_READ:   state_q <= CMD_RD_ADDR;
              OP_STATUS: dump_start_q <= 1'b1;
              default:   state_q <= CMD_IDLE;  // Unknown opcode
            endcase
          end
        end
        CMD_WR_ADDR: begin
          if (rx_take) begin
            state_q    <= CMD_WR_DATA;
            data_cnt_q <= '0;
          end
        end
        CMD_WR_DATA: begin
          if (rx_take) begin
            data_cnt_q <= data_cnt_q + 1'b1;
            if (data_cnt_q == 2'd3) begin  // Last of four data bytes
              mem_we_q <= 1'b1;
              wr_cnt_q <= wr_cnt_q + 1'b1;
              state_q  <= CMD_IDLE;
            end
          end
        end
        CMD_RD_ADDR: begin
          if (rx_take) begin
            mem_re_q <= 1'b1;
            state_q  <= CMD_RD_WAIT;
          end
        end
        CMD_RD_WAIT: state_q <= CMD_RD_LOAD;  // Store read in flight
        CMD_RD_LOAD: begin
          dump_start_q <= 1'b1;
          rd_cnt_q     <= rd_cnt_q + 1'b1;
          state_q      <= CMD_IDLE;
        end
        default: state_q <= CMD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (rx_take && (state_q == CMD_WR_ADDR || state_q == CMD_RD_ADDR)) begin
      mem_addr_q <= addr_t'(rx_byte_i);
    end
    if (rx_take && state_q == CMD_WR_DATA) begin
      wdata_q <= {wdata_q[WORD_BITS-9:0], rx_byte_i};  // Most significant byte first
    end
    if (state_q == CMD_RD_LOAD) begin
      dump_word_q <= mem_rdata_i;
    end else if (state_q == CMD_IDLE && rx_take && rx_byte_i == OP_STATUS) begin
      dump_word_q <= {rd_cnt_q, wr_cnt_q};
    end
  end

  assign mem_we_o     = mem_we_q;
  assign mem_re_o     = mem_re_q;
  assign mem_addr_o   = mem_addr_q;
  assign mem_wdata_o  = wdata_q;
  assign dump_start_o = dump_start_q;
  assign dump_word_o  = dump_word_q;
  assign configured_o = configured_q;

endmodule

`default_nettype wire

/* design/word_store.sv */
`default_nettype none

module word_store
  import memprobe_pkg::*;
(
  input  logic  clock,
  input  logic  we_i,
  input  logic  re_i,
  input  addr_t addr_i,
  input  word_t wdata_i,
  output word_t rdata_o
);

  localparam int DEPTH = 2 ** ADDR_BITS;

  word_t mem_q [DEPTH];
  word_t rdata_q;

  always_ff @(posedge clock) begin
    if (we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
  end

  // Registered read, data valid the cycle after re_i
  always_ff @(posedge clock) begin
    if (re_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* design/hex_dump.sv */
`default_nettype none

module hex_dump
  import memprobe_pkg::*;
(
  input  logic  clock,
  input  logic  reset_i,
  input  logic  start_i,
  input  word_t word_i,
  input  logic  ready_i,
  output logic  valid_o,
  output byte_t data_o,
  output logic  is_dumping_o
);

  logic     active_q;
  logic     nl_q;     // Nibbles done, newline pending
  nib_idx_t nib_q;
  word_t    word_q;
  logic     take;

  function automatic byte_t hex_char(input logic [3:0] nibble);
    if (nibble < 4'd10) begin
      hex_char = byte_t'("0") + byte_t'(nibble);
    end else begin
      hex_char = byte_t'("a") + byte_t'(nibble) - 8'd10;
    end
  endfunction

  assign take = active_q && ready_i;

  always_ff @(posedge clock) begin
    if (reset_i) begin
      active_q <= 1'b0;
      nl_q     <= 1'b0;
      nib_q    <= NIB_FIRST;
    end else if (!active_q) begin
      if (start_i) begin
        active_q <= 1'b1;
        nl_q     <= 1'b0;
        nib_q    <= NIB_FIRST;
      end
    end else if (take) begin
      if (nl_q) begin
        active_q <= 1'b0;  // Newline accepted, reply complete
        nl_q     <= 1'b0;
      end else if (nib_q == '0) begin
        nl_q <= 1'b1;
      end else begin
        nib_q <= nib_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (start_i && !active_q) begin
      word_q <= word_i;
    end
  end

  // Character held steady until the transmitter takes it
  assign data_o       = nl_q ? CHAR_NEWLINE : hex_char(word_q[{nib_q, 2'b00} +: 4]);
  assign valid_o      = active_q;
  assign is_dumping_o = active_q;

endmodule

`default_nettype wire

/* design/memprobe_top.sv */
`default_nettype none

module memprobe_top
  import memprobe_pkg::*;
(
  input  logic clock,
  input  logic reset_i,
  input  logic rx_i,
  output logic tx_o,
  output logic configured_o
);

  byte_t rx_byte;
  logic  rx_strobe;
  logic  mem_we;
  logic  mem_re;
  addr_t mem_addr;
  word_t mem_wdata;
  word_t mem_rdata;
  logic  dump_start;
  word_t dump_word;
  logic  is_dumping;
  logic  char_valid;
  logic  char_ready;
  byte_t char_data;

  uart_rx u_rx (
    .clock   (clock),
    .reset_i (reset_i),
    .rx_i    (rx_i),
    .byte_o  (rx_byte),
    .strobe_o(rx_strobe)
  );

  cmd_ctrl u_ctrl (
    .clock       (clock),
    .reset_i     (reset_i),
    .rx_byte_i   (rx_byte),
    .rx_strobe_i (rx_strobe),
    .dumping_i   (is_dumping),
    .mem_rdata_i (mem_rdata),
    .mem_we_o    (mem_we),
    .mem_re_o    (mem_re),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .dump_start_o(dump_start),
    .dump_word_o (dump_word),
    .configured_o(configured_o)
  );

  word_store u_store (
    .clock  (clock),
    .we_i   (mem_we),
    .re_i   (mem_re),
    .addr_i (mem_addr),
    .wdata_i(mem_wdata),
    .rdata_o(mem_rdata)
  );

  hex_dump u_dump (
    .clock       (clock),
    .reset_i     (reset_i),
    .start_i     (dump_start),
    .word_i      (dump_word),
    .ready_i     (char_ready),
    .valid_o     (char_valid),
    .data_o      (char_data),
    .is_dumping_o(is_dumping)
  );

  uart_tx u_tx (
    .clock  (clock),
    .reset_i(reset_i),
    .valid_i(char_valid),
    .data_i (char_data),
    .ready_o(char_ready),
    .busy_o (),
    .tx_o   (tx_o)
  );

endmodule

`default_nettype wire

/* verification/memprobe_assert.sv */
`default_nettype none

module memprobe_assert (
  input logic clock,
  input logic reset_i,
  input logic mem_we_i,
  input logic mem_re_i,
  input logic dump_start_i,
  input logic is_dumping_i,
  input logic tx_i
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_count = 0;

  // Store strobes are exclusive
  we_re_exclusive: assert property (
    @(posedge clock) disable iff (reset_i) !(mem_we_i && mem_re_i))
    else begin
      fail_count++;
      $error("Store write and read strobes high together");
    end

  // A new reply never starts on top of one in progress
  start_while_idle: assert property (
    @(posedge clock) disable iff (reset_i) !(dump_start_i && is_dumping_i))
    else begin
      fail_count++;
      $error("dump_start fired while a reply was being sent");
    end

  tx_idle_after_reset: assert property (@(posedge clock) reset_i |=> tx_i)
    else begin
      fail_count++;
      $error("tx_o not high in the cycle after reset");
    end

endmodule

bind memprobe_top memprobe_assert checks (
  .clock       (clock),
  .reset_i     (reset_i),
  .mem_we_i    (mem_we),
  .mem_re_i    (mem_re),
  .dump_start_i(dump_start),
  .is_dumping_i(is_dumping),
  .tx_i        (tx_o)
);

`default_nettype wire

/* verification/memprobe_tb.sv */
`default_nettype none

module memprobe_tb
  import memprobe_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // About 155 serial bytes of 160 clocks each, plus margin
  localparam int CYCLE_LIMIT = 60000;

  logic clock;
  logic reset_i;
  logic rx_i;
  logic tx_o;
  logic configured_o;

  integer      seed = 32'hcd0c;
  int unsigned cycles = 0;
  int unsigned writes_done = 0;
  int unsigned reads_done = 0;
  word_t       model [2**ADDR_BITS];  // Expected store contents
  addr_t       addrs [4];
  byte_t       reply_chars [9];

  memprobe_top dut (
    .clock       (clock),
    .reset_i     (reset_i),
    .rx_i        (rx_i),
    .tx_o        (tx_o),
    .configured_o(configured_o)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  task automatic stop_run();
    $display("Test failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the DUT stopped answering", cycles);
      stop_run();
    end
  end

  function automatic byte_t expected_char(input logic [3:0] nibble);
    string digits;
    digits = "0123456789abcdef";
    return digits[nibble];
  endfunction

  task automatic compare_byte(input string name, input byte_t expected, input byte_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: expected 8'h%02h, got 8'h%02h", name, expected, actual);
      stop_run();
    end
  endtask

  task automatic compare_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: expected 32'h%08h, got 32'h%08h", name, expected, actual);
      stop_run();
    end
  endtask

  // Start bit, eight data bits LSB first, stop bit
  task automatic send_byte(input byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(negedge clock);
      rx_i = frame[i];
      repeat (UART_BIT_CYCLES - 1) @(negedge clock);
    end
  endtask

  task automatic receive_byte(output byte_t b);
    @(negedge clock);
    while (tx_o !== 1'b0) @(negedge clock);
    repeat (UART_BIT_CYCLES / 2) @(negedge clock);  // Middle of start bit
    if (tx_o !== 1'b0) begin
      $display("Start bit on tx_o ended before its middle");
      stop_run();
    end
    for (int i = 0; i < 8; i++) begin
      repeat (UART_BIT_CYCLES) @(negedge clock);
      b[i] = tx_o;
    end
    repeat (UART_BIT_CYCLES) @(negedge clock);
    if (tx_o !== 1'b1) begin
      $display("Stop bit on tx_o was low");
      stop_run();
    end
  endtask

  // Eight hex digits then a newline
  task automatic get_reply(output word_t w);
    byte_t      c;
    logic [3:0] nib;
    w = '0;
    for (int i = 0; i < 9; i++) begin
      receive_byte(c);
      reply_chars[i] = c;
    end
    for (int i = 0; i < NIBBLES; i++) begin
      c = reply_chars[i];
      if (c >= "0" && c <= "9") begin
        nib = 4'(c - "0");
      end else if (c >= "a" && c <= "f") begin
        nib = 4'(c - "a" + 8'd10);
      end else if (c >= "A" && c <= "F") begin
        nib = 4'(c - "A" + 8'd10);
      end else begin
        $display("Reply character 8'h%02h is not a hex digit", c);
        stop_run();
      end
      w = {w[WORD_BITS-5:0], nib};
    end
    if (reply_chars[8] !== CHAR_NEWLINE) begin
      $display("Reply did not end with a newline");
      stop_run();
    end
  endtask

  task automatic check_reply(input string name, input word_t expected, input word_t actual);
    compare_word(name, expected, actual);
    for (int i = 0; i < NIBBLES; i++) begin  // Digits must be lower case
      compare_byte(name, expected_char(expected[WORD_BITS-4-4*i +: 4]), reply_chars[i]);
    end
  endtask

  task automatic send_write(input addr_t a, input word_t w);
    send_byte(OP_WRITE);
    send_byte(byte_t'(a));
    for (int i = 3; i >= 0; i--) begin
      send_byte(w[8*i +: 8]);  // Most significant byte first
    end
  endtask

  task automatic store_word(input addr_t a, input word_t w);
    send_write(a, w);
    model[a] = w;
    writes_done++;
  endtask

  task automatic read_check(input string name, input addr_t a);
    word_t got;
    fork
      begin
        send_byte(OP_READ);
        send_byte(byte_t'(a));
      end
      get_reply(got);
    join
    reads_done++;
    check_reply(name, model[a], got);
  endtask

  // Reads in the upper half, writes in the lower half
  task automatic status_check(input string name);
    word_t got;
    fork
      send_byte(OP_STATUS);
      get_reply(got);
    join
    check_reply(name, {COUNT_BITS'(reads_done), COUNT_BITS'(writes_done)}, got);
  endtask

  task automatic test_reset();
    repeat (200) begin
      @(negedge clock);
      if (tx_o !== 1'b1) begin
        $display("tx_o left its idle level after reset");
        stop_run();
      end
    end
    if (configured_o !== 1'b1) begin
      $display("configured_o is not high after reset");
      stop_run();
    end
  endtask

  task automatic test_write_read();
    for (int i = 0; i < 4; i++) begin
      addrs[i] = {6'($random(seed)), 2'(i)};  // Low bits keep them distinct
      store_word(addrs[i], $random(seed));
    end
    for (int i = 0; i < 4; i++) begin
      read_check("write_read", addrs[i]);
    end
  endtask

  task automatic test_overwrite();
    word_t first;
    first = $random(seed);
    store_word(8'h5a, first);
    store_word(8'h5a, ~first);
    read_check("overwrite", 8'h5a);
  endtask

  task automatic test_ignored();
    send_byte(8'h3f);  // Not an opcode
    read_check("ignored_read", addrs[0]);
    status_check("ignored_status");
  endtask

  task automatic test_drop();
    word_t got;
    fork
      begin
        send_byte(OP_READ);
        send_byte(byte_t'(addrs[1]));
        while (tx_o !== 1'b0) @(negedge clock);  // Reply under way
        send_write(addrs[1], ~model[addrs[1]]);
      end
      get_reply(got);
    join
    reads_done++;
    check_reply("drop_reply", model[addrs[1]], got);
    read_check("drop_readback", addrs[1]);
  endtask

  initial begin
    reset_i = 1'b1;
    rx_i    = 1'b1;
    repeat (3) @(negedge clock);
    reset_i = 1'b0;
    test_reset();
    test_write_read();
    test_overwrite();
    status_check("status");
    test_ignored();
    test_drop();
    if (dut.checks.fail_count == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("Bound assertions failed %0d times", dut.checks.fail_count);
      stop_run();
    end
  end

endmodule

`default_nettype wire

/* memprobe_top.f */
design/memprobe_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/cmd_ctrl.sv
design/word_store.sv
design/hex_dump.sv
design/memprobe_top.sv
verification/memprobe_assert.sv
verification/memprobe_tb.sv

/* Bender.yml */
package:
  name: memprobe

sources:
  - design/memprobe_pkg.sv
  - design/uart_rx.sv
  - design/uart_tx.sv
  - design/cmd_ctrl.sv
  - design/word_store.sv
  - design/hex_dump.sv
  - design/memprobe_top.sv
  - target: test
    files:
      - verification/memprobe_assert.sv
      - verification/memprobe_tb.sv
